// ==== axil_pause.sv ====
// AXI-Lite pause gate
`timescale 1ns/1ps

module axil_pause import axil_xbar_pkg::*; (
    input  logic       clk,
    input  logic       reset_i,

    input  logic       pause_req_i,
    output logic       pause_ack_o,

    input  axil_req_t  slv_req_i,
    output axil_resp_t slv_resp_o,

    output axil_req_t  gated_req_o,
    input  axil_resp_t gated_resp_i
);

    logic outstanding_q;
    logic pause_ack_q;
    logic block;
    logic accept;
    logic complete;

    // Port stays closed until the ack has dropped again
    assign block = pause_req_i || pause_ack_q;

    always_comb begin
        gated_req_o = slv_req_i;
        slv_resp_o  = gated_resp_i;
        if (block) begin
            gated_req_o.aw_valid = 1'b0;
            gated_req_o.w_valid  = 1'b0;
            gated_req_o.ar_valid = 1'b0;
            slv_resp_o.aw_ready  = 1'b0;
            slv_resp_o.w_ready   = 1'b0;
            slv_resp_o.ar_ready  = 1'b0;
        end
    end

    // Handshakes seen on the router side
    assign accept = (gated_req_o.aw_valid && gated_req_o.w_valid &&
                     gated_resp_i.aw_ready && gated_resp_i.w_ready) ||
                    (gated_req_o.ar_valid && gated_resp_i.ar_ready);

    assign complete = (gated_resp_i.b_valid && gated_req_o.b_ready) ||
                      (gated_resp_i.r_valid && gated_req_o.r_ready);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            outstanding_q <= 1'b0;
            pause_ack_q   <= 1'b0;
        end else begin
            if (accept) begin
                outstanding_q <= 1'b1;
            end else if (complete) begin
                outstanding_q <= 1'b0;
            end
            // Ack once paused and nothing is in flight
            pause_ack_q <= pause_req_i && !outstanding_q;
        end
    end

    assign pause_ack_o = pause_ack_q;

    // A port that reported idle takes no new request
    a_no_accept_when_acked: assert property (
        @(posedge clk) disable iff (reset_i)
        pause_ack_o |=> !outstanding_q
    );

endmodule

// ==== axil_port_router.sv ====
// AXI-Lite port router
`timescale 1ns/1ps

module axil_port_router import axil_xbar_pkg::*; (
    input  logic                       clk,
    input  logic                       reset_i,

    input  axil_req_t                  req_i,
    output axil_resp_t                 resp_o,

    input  addr_rule_t [NUM_MST-1:0]   addr_map_i,

    output axil_req_t                  rt_req_o,
    output logic       [NUM_MST-1:0]   rt_sel_o,
    input  axil_resp_t [NUM_MST-1:0]   rt_resp_i
);

    router_state_e      state_q;
    axil_req_t          req_q;
    logic [NUM_MST-1:0] sel_q;
    logic               addr_done_q;
    logic               data_done_q;

    logic               wr_req;
    logic               rd_req;
    logic [NUM_MST-1:0] aw_sel;
    logic [NUM_MST-1:0] ar_sel;
    axil_resp_t         sel_resp;

    // First matching rule wins, zero when no rule matches
    function automatic logic [NUM_MST-1:0] decode_sel(
        input logic [ADDR_WIDTH-1:0]    addr,
        input addr_rule_t [NUM_MST-1:0] map
    );
        logic [NUM_MST-1:0] sel;
        sel = '0;
        for (int j = 0; j < NUM_MST; j++) begin
            if (sel == '0 && addr >= map[j].start_addr && addr < map[j].end_addr) begin
                sel[map[j].idx] = 1'b1;
            end
        end
        return sel;
    endfunction

    // Writes take priority when both arrive together
    assign wr_req = req_i.aw_valid && req_i.w_valid;
    assign rd_req = req_i.ar_valid && !wr_req;
    assign aw_sel = decode_sel(req_i.aw_addr, addr_map_i);
    assign ar_sel = decode_sel(req_i.ar_addr, addr_map_i);

    always_comb begin
        sel_resp = '0;
        for (int j = 0; j < NUM_MST; j++) begin
            if (sel_q[j]) begin
                sel_resp = rt_resp_i[j];
            end
        end
    end

    always_comb begin
        resp_o   = '0;
        rt_req_o = '0;
        case (state_q)
            ROUTE_IDLE: begin
                resp_o.aw_ready = wr_req;
                resp_o.w_ready  = wr_req;
                resp_o.ar_ready = rd_req;
            end
            ROUTE_WRITE: begin
                rt_req_o          = req_q;
                rt_req_o.aw_valid = !addr_done_q;
                rt_req_o.w_valid  = !data_done_q;
                rt_req_o.b_ready  = req_i.b_ready;
                rt_req_o.ar_valid = 1'b0;
                rt_req_o.r_ready  = 1'b0;
                resp_o.b_valid    = sel_resp.b_valid;
                resp_o.b_resp     = sel_resp.b_resp;
            end
            ROUTE_READ: begin
                rt_req_o          = req_q;
                rt_req_o.aw_valid = 1'b0;
                rt_req_o.w_valid  = 1'b0;
                rt_req_o.b_ready  = 1'b0;
                rt_req_o.ar_valid = !addr_done_q;
                rt_req_o.r_ready  = req_i.r_ready;
                resp_o.r_valid    = sel_resp.r_valid;
                resp_o.r_data     = sel_resp.r_data;
                resp_o.r_resp     = sel_resp.r_resp;
            end
            ROUTE_DECERR_B: begin
                resp_o.b_valid = 1'b1;
                resp_o.b_resp  = RESP_DECERR;
            end
            ROUTE_DECERR_R: begin
                resp_o.r_valid = 1'b1;
                resp_o.r_resp  = RESP_DECERR;
            end
            default: begin
            end
        endcase
    end

    assign rt_sel_o = sel_q;

    always_ff @(posedge clk) begin
        if (state_q == ROUTE_IDLE && (wr_req || rd_req)) begin
            req_q <= req_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q     <= ROUTE_IDLE;
            sel_q       <= '0;
            addr_done_q <= 1'b0;
            data_done_q <= 1'b0;
        end else begin
            case (state_q)
                ROUTE_IDLE: begin
                    addr_done_q <= 1'b0;
                    data_done_q <= 1'b0;
                    if (wr_req) begin
                        sel_q   <= aw_sel;
                        state_q <= (aw_sel != '0) ? ROUTE_WRITE : ROUTE_DECERR_B;
                    end else if (rd_req) begin
                        sel_q   <= ar_sel;
                        state_q <= (ar_sel != '0) ? ROUTE_READ : ROUTE_DECERR_R;
                    end
                end
                ROUTE_WRITE: begin
                    // Target may take AW and W in different cycles
                    if (rt_req_o.aw_valid && sel_resp.aw_ready) addr_done_q <= 1'b1;
                    if (rt_req_o.w_valid && sel_resp.w_ready) data_done_q <= 1'b1;
                    if (sel_resp.b_valid && req_i.b_ready) begin
                        state_q <= ROUTE_IDLE;
                        sel_q   <= '0;
                    end
                end
                ROUTE_READ: begin
                    if (rt_req_o.ar_valid && sel_resp.ar_ready) addr_done_q <= 1'b1;
                    if (sel_resp.r_valid && req_i.r_ready) begin
                        state_q <= ROUTE_IDLE;
                        sel_q   <= '0;
                    end
                end
                ROUTE_DECERR_B: begin
                    if (req_i.b_ready) state_q <= ROUTE_IDLE;
                end
                ROUTE_DECERR_R: begin
                    if (req_i.r_ready) state_q <= ROUTE_IDLE;
                end
                default: state_q <= ROUTE_IDLE;
            endcase
        end
    end

    // At most one target, and only while a routed transaction is open
    a_sel_onehot: assert property (
        @(posedge clk) disable iff (reset_i)
        $onehot0(rt_sel_o) &&
        ((rt_sel_o != '0) == (state_q == ROUTE_WRITE || state_q == ROUTE_READ))
    );

endmodule

// ==== axil_target_arbiter.sv ====
// AXI-Lite target arbiter
`timescale 1ns/1ps

module axil_target_arbiter import axil_xbar_pkg::*; (
    input  logic                       clk,
    input  logic                       reset_i,

    input  addr_rule_t                 rule_i,

    input  axil_req_t  [NUM_SLV-1:0]   rt_req_i,
    input  logic       [NUM_SLV-1:0]   rt_sel_i,
    output axil_resp_t [NUM_SLV-1:0]   rt_resp_o,

    output axil_req_t                  mst_req_o,
    input  axil_resp_t                 mst_resp_i
);

    arb_state_e               state_q;
    logic [SLV_IDX_WIDTH-1:0] grant_q;

    logic [NUM_SLV-1:0]       req_vec;
    logic                     any_req;
    logic [SLV_IDX_WIDTH-1:0] next_grant;
    axil_req_t                win_req;
    logic                     locked;

    assign locked  = (state_q != ARB_IDLE);
    assign win_req = rt_req_i[grant_q];

    // A router requests only while it selects us and holds a valid
    always_comb begin
        for (int i = 0; i < NUM_SLV; i++) begin
            req_vec[i] = rt_sel_i[i] && (rt_req_i[i].aw_valid || rt_req_i[i].ar_valid);
        end
    end

    // Round robin, search starts just after the last grant
    always_comb begin
        int cand;
        next_grant = grant_q;
        any_req    = 1'b0;
        for (int k = 1; k <= NUM_SLV; k++) begin
            cand = (int'(grant_q) + k) % NUM_SLV;
            if (!any_req && req_vec[cand]) begin
                any_req    = 1'b1;
                next_grant = SLV_IDX_WIDTH'(cand);
            end
        end
    end

    // Forward the winner with addresses made relative to the target base
    always_comb begin
        mst_req_o = '0;
        if (locked) begin
            mst_req_o         = win_req;
            mst_req_o.aw_addr = win_req.aw_addr - rule_i.start_addr;
            mst_req_o.ar_addr = win_req.ar_addr - rule_i.start_addr;
        end
    end

    // Only the winner hears from the target
    always_comb begin
        rt_resp_o = '0;
        if (locked) begin
            rt_resp_o[grant_q] = mst_resp_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= ARB_IDLE;
            grant_q <= SLV_IDX_WIDTH'(NUM_SLV - 1);
        end else begin
            case (state_q)
                ARB_IDLE: begin
                    if (any_req) begin
                        grant_q <= next_grant;
                        state_q <= rt_req_i[next_grant].aw_valid ? ARB_WRITE : ARB_READ;
                    end
                end
                ARB_WRITE: begin
                    if (mst_resp_i.b_valid && mst_req_o.b_ready) begin
                        state_q <= ARB_IDLE;
                    end
                end
                ARB_READ: begin
                    if (mst_resp_i.r_valid && mst_req_o.r_ready) begin
                        state_q <= ARB_IDLE;
                    end
                end
                default: state_q <= ARB_IDLE;
            endcase
        end
    end

    // The winner keeps selecting this target for the whole lock
    a_grant_stable: assert property (
        @(posedge clk) disable iff (reset_i)
        locked |-> rt_sel_i[grant_q]
    );

endmodule

// ==== axil_xbar.f ====
axil_xbar_pkg.sv
axil_pause.sv
axil_port_router.sv
axil_target_arbiter.sv
axil_xbar.sv
tb_clock_gen.sv
tb_axil_checker.sv
tb_axil_xbar.sv

// ==== axil_xbar.sv ====
// AXI-Lite crossbar top
`timescale 1ns/1ps

module axil_xbar import axil_xbar_pkg::*; (
    input  logic                       clk,
    input  logic                       reset_i,

    input  logic                       pause_req_i,
    output logic                       pause_ack_o,

    input  axil_req_t  [NUM_SLV-1:0]   slv_req_i,
    output axil_resp_t [NUM_SLV-1:0]   slv_resp_o,

    output axil_req_t  [NUM_MST-1:0]   mst_req_o,
    input  axil_resp_t [NUM_MST-1:0]   mst_resp_i,

    // Rule j is expected to carry idx j
    input  addr_rule_t [NUM_MST-1:0]   addr_map_i
);

    logic       [NUM_SLV-1:0]               gate_ack;
    axil_req_t  [NUM_SLV-1:0]               gated_req;
    axil_resp_t [NUM_SLV-1:0]               gated_resp;

    // Router side, indexed by slave then target
    axil_req_t  [NUM_SLV-1:0]               rt_req;
    logic       [NUM_SLV-1:0][NUM_MST-1:0]  rt_sel;
    axil_resp_t [NUM_SLV-1:0][NUM_MST-1:0]  rt_resp;

    // Arbiter side, indexed by target then slave
    logic       [NUM_MST-1:0][NUM_SLV-1:0]  arb_sel;
    axil_resp_t [NUM_MST-1:0][NUM_SLV-1:0]  arb_resp;

    for (genvar i = 0; i < NUM_SLV; i++) begin : g_slv
        axil_pause u_pause (
            .clk          (clk),
            .reset_i      (reset_i),
            .pause_req_i  (pause_req_i),
            .pause_ack_o  (gate_ack[i]),
            .slv_req_i    (slv_req_i[i]),
            .slv_resp_o   (slv_resp_o[i]),
            .gated_req_o  (gated_req[i]),
            .gated_resp_i (gated_resp[i])
        );

        axil_port_router u_router (
            .clk        (clk),
            .reset_i    (reset_i),
            .req_i      (gated_req[i]),
            .resp_o     (gated_resp[i]),
            .addr_map_i (addr_map_i),
            .rt_req_o   (rt_req[i]),
            .rt_sel_o   (rt_sel[i]),
            .rt_resp_i  (rt_resp[i])
        );
    end

    for (genvar j = 0; j < NUM_MST; j++) begin : g_mst
        axil_target_arbiter u_arb (
            .clk        (clk),
            .reset_i    (reset_i),
            .rule_i     (addr_map_i[j]),
            .rt_req_i   (rt_req),
            .rt_sel_i   (arb_sel[j]),
            .rt_resp_o  (arb_resp[j]),
            .mst_req_o  (mst_req_o[j]),
            .mst_resp_i (mst_resp_i[j])
        );
    end

    // Swap between per-router and per-target views
    always_comb begin
        for (int i = 0; i < NUM_SLV; i++) begin
            for (int j = 0; j < NUM_MST; j++) begin
                arb_sel[j][i] = rt_sel[i][j];
                rt_resp[i][j] = arb_resp[j][i];
            end
        end
    end

    // All gates must ack to pause, all must release before the ack falls
    assign pause_ack_o = pause_req_i ? (&gate_ack) : (|gate_ack);

endmodule

// ==== axil_xbar_pkg.sv ====
// AXI-Lite crossbar definitions
package axil_xbar_pkg;

    // Bus widths
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;
    localparam int PROT_WIDTH = 3;

    // Port counts and index widths
    localparam int NUM_SLV       = 2;
    localparam int NUM_MST       = 2;
    localparam int TGT_IDX_WIDTH = 1;
    localparam int SLV_IDX_WIDTH = 1;

    // AXI response encodings
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } axil_resp_e;

    // Initiator to target side of all five channels
    typedef struct packed {
        logic                  aw_valid;
        logic [ADDR_WIDTH-1:0] aw_addr;
        logic [PROT_WIDTH-1:0] aw_prot;
        logic                  w_valid;
        logic [DATA_WIDTH-1:0] w_data;
        logic [STRB_WIDTH-1:0] w_strb;
        logic                  b_ready;
        logic                  ar_valid;
        logic [ADDR_WIDTH-1:0] ar_addr;
        logic [PROT_WIDTH-1:0] ar_prot;
        logic                  r_ready;
    } axil_req_t;

    // Target to initiator side
    typedef struct packed {
        logic                  aw_ready;
        logic                  w_ready;
        logic                  b_valid;
        axil_resp_e            b_resp;
        logic                  ar_ready;
        logic                  r_valid;
        logic [DATA_WIDTH-1:0] r_data;
        axil_resp_e            r_resp;
    } axil_resp_t;

    // Address window, end_addr is exclusive
    typedef struct packed {
        logic [TGT_IDX_WIDTH-1:0] idx;
        logic [ADDR_WIDTH-1:0]    start_addr;
        logic [ADDR_WIDTH-1:0]    end_addr;
    } addr_rule_t;

    typedef enum logic [2:0] {
        ROUTE_IDLE,
        ROUTE_WRITE,
        ROUTE_READ,
        ROUTE_DECERR_B,
        ROUTE_DECERR_R
    } router_state_e;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_WRITE,
        ARB_READ
    } arb_state_e;

endpackage

// ==== axil_xbar_testdata.txt ====
# op port addr wdata strb exp_rdata exp_resp exp_tgt exp_taddr (hex, tgt 3 means no target)
# C writes wdata at addr from port 0 and exp_rdata at addr+4 from port 1
W 0 00001004 11223344 f 00000000 0 0 00000004
R 0 00001004 00000000 0 11223344 0 0 00000004
W 1 00002010 a5a5a5a5 f 00000000 0 1 00000010
R 1 00002010 00000000 0 a5a5a5a5 0 1 00000010
W 1 00001008 cafef00d f 00000000 0 0 00000008
R 0 00001008 00000000 0 cafef00d 0 0 00000008
W 0 000020fc 0badf00d f 00000000 0 1 000000fc
R 1 000020fc 00000000 0 0badf00d 0 1 000000fc
W 0 00003000 deadbeef f 00000000 3 3 00000000
R 1 00000ff0 00000000 0 00000000 3 3 00000000
R 0 00001100 00000000 0 00000000 3 3 00000000
W 1 00002100 12345678 f 00000000 3 3 00000000
W 0 00001004 ffffffff 5 00000000 0 0 00000004
R 1 00001004 00000000 0 11ff33ff 0 0 00000004
W 1 00002010 12345678 4 00000000 0 1 00000010
R 0 00002010 00000000 0 a534a5a5 0 1 00000010
W 0 00001008 00000099 1 00000000 0 0 00000008
R 0 00001008 00000000 0 cafef099 0 0 00000008
C 0 00001020 aaaa0001 f bbbb0002 0 0 00000000
R 0 00001024 00000000 0 bbbb0002 0 0 00000024
R 1 00001020 00000000 0 aaaa0001 0 0 00000020
C 0 00002040 cccc0003 f dddd0004 0 1 00000000
R 1 00002044 00000000 0 dddd0004 0 1 00000044
R 0 00002040 00000000 0 cccc0003 0 1 00000040
P 1 00001020 00000000 0 aaaa0001 0 0 00000020
P 0 00002010 00000000 0 a534a5a5 0 1 00000010

// ==== run_sim.sh ====
#!/bin/bash
# Build and run the crossbar testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_axil_xbar \
    -f axil_xbar.f -o sim_tb > build.log 2>&1 \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "Build or run failed"; exit 1; }

cat sim.log
grep -q '\*\*\* PASSED \*\*\*' sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

// ==== tb_axil_checker.sv ====
// Crossbar response monitor
`timescale 1ns/1ps

module tb_axil_checker import axil_xbar_pkg::*; (
    input  logic                     clk,
    input  logic                     reset_i,
    input  axil_req_t  [NUM_SLV-1:0] slv_req_i,
    input  axil_resp_t [NUM_SLV-1:0] slv_resp_i,
    input  axil_req_t  [NUM_MST-1:0] mst_req_i,
    input  axil_resp_t [NUM_MST-1:0] mst_resp_i,
    input  logic                     pause_ack_i,
    input  logic                     start_i,
    input  logic                     check_i,
    input  int                       test_id_i,
    input  int                       port_i,
    input  logic [1:0]               exp_resp_i,
    input  logic [DATA_WIDTH-1:0]    exp_rdata_i,
    input  logic                     chk_data_i,
    input  logic                     chk_tgt_i,
    input  int                       exp_tgt_i,
    input  logic [ADDR_WIDTH-1:0]    exp_taddr_i,
    output int                       pass_cnt_o,
    output int                       fail_cnt_o
);

    logic [NUM_SLV-1:0]    got_done;
    logic [1:0]            got_resp [NUM_SLV];
    logic [DATA_WIDTH-1:0] got_data [NUM_SLV];
    int                    hits;
    int                    last_tgt;
    logic [ADDR_WIDTH-1:0] last_taddr;

    initial begin
        pass_cnt_o = 0;
        fail_cnt_o = 0;
    end

    // Capture responses per port and target-side handshakes
    always @(posedge clk) begin
        if (reset_i || start_i) begin
            got_done <= '0;
            hits     <= 0;
        end else begin
            for (int i = 0; i < NUM_SLV; i++) begin
                if (slv_resp_i[i].b_valid && slv_req_i[i].b_ready) begin
                    got_done[i] <= 1'b1;
                    got_resp[i] <= slv_resp_i[i].b_resp;
                    got_data[i] <= '0;
                end
                if (slv_resp_i[i].r_valid && slv_req_i[i].r_ready) begin
                    got_done[i] <= 1'b1;
                    got_resp[i] <= slv_resp_i[i].r_resp;
                    got_data[i] <= slv_resp_i[i].r_data;
                end
            end
            for (int j = 0; j < NUM_MST; j++) begin
                if (mst_req_i[j].aw_valid && mst_resp_i[j].aw_ready) begin
                    hits       <= hits + 1;
                    last_tgt   <= j;
                    last_taddr <= mst_req_i[j].aw_addr;
                end
                if (mst_req_i[j].ar_valid && mst_resp_i[j].ar_ready) begin
                    hits       <= hits + 1;
                    last_tgt   <= j;
                    last_taddr <= mst_req_i[j].ar_addr;
                end
            end
        end
    end

    always @(posedge clk) begin
        // A paused crossbar keeps every target quiet and takes no request
        if (!reset_i && pause_ack_i) begin
            for (int j = 0; j < NUM_MST; j++) begin
                if (mst_req_i[j].aw_valid || mst_req_i[j].ar_valid) begin
                    $display("[FAIL] %0t: target %0d sees a valid while paused", $time, j);
                    fail_cnt_o++;
                end
            end
            for (int i = 0; i < NUM_SLV; i++) begin
                if (slv_resp_i[i].aw_ready || slv_resp_i[i].ar_ready) begin
                    $display("[FAIL] %0t: port %0d sees a ready while paused", $time, i);
                    fail_cnt_o++;
                end
            end
        end
        if (!reset_i && check_i) begin
            bit ok;
            ok = 1'b1;
            if (!got_done[port_i]) begin
                $display("Test %0d: port %0d finished without a response", test_id_i, port_i);
                ok = 1'b0;
            end else if (got_resp[port_i] != exp_resp_i) begin
                $display("[FAIL] %0t: test %0d port %0d resp %0d, expected %0d",
                         $time, test_id_i, port_i, got_resp[port_i], exp_resp_i);
                ok = 1'b0;
            end else if (chk_data_i && got_data[port_i] != exp_rdata_i) begin
                $display("[FAIL] %0t: test %0d port %0d data %h, expected %h",
                         $time, test_id_i, port_i, got_data[port_i], exp_rdata_i);
                ok = 1'b0;
            end
            if (chk_tgt_i && exp_tgt_i >= NUM_MST && hits != 0) begin
                $display("[FAIL] %0t: test %0d reached a target on a decode error",
                         $time, test_id_i);
                ok = 1'b0;
            end else if (chk_tgt_i && exp_tgt_i < NUM_MST &&
                         (hits != 1 || last_tgt != exp_tgt_i || last_taddr != exp_taddr_i)) begin
                $display("[FAIL] %0t: test %0d target %0d addr %h hits %0d, expected %0d %h",
                         $time, test_id_i, last_tgt, last_taddr, hits, exp_tgt_i, exp_taddr_i);
                ok = 1'b0;
            end
            if (ok) begin
                $display("Test %0d port %0d ok", test_id_i, port_i);
                pass_cnt_o++;
            end else begin
                fail_cnt_o++;
            end
        end
    end

endmodule

// ==== tb_axil_xbar.sv ====
// Crossbar testbench top
`timescale 1ns/1ps

module tb_axil_xbar import axil_xbar_pkg::*; ();

    localparam int MAX_VEC = 64;

    logic clk, reset_i, pause_req, pause_ack;
    axil_req_t  [NUM_SLV-1:0] slv_req;
    axil_resp_t [NUM_SLV-1:0] slv_resp;
    axil_req_t  [NUM_MST-1:0] mst_req;
    axil_resp_t [NUM_MST-1:0] mst_resp;
    addr_rule_t [NUM_MST-1:0] addr_map;

    logic start, check, chk_data, chk_tgt;
    logic [1:0] exp_resp;
    logic [31:0] exp_rdata, exp_taddr;
    int test_id, chk_port, exp_tgt, pass_cnt, fail_cnt, nvec, cycles, limit;

    logic [7:0]  v_op [MAX_VEC];
    logic [31:0] v_port [MAX_VEC], v_addr [MAX_VEC], v_wdata [MAX_VEC], v_strb [MAX_VEC];
    logic [31:0] v_rdata [MAX_VEC], v_resp [MAX_VEC], v_tgt [MAX_VEC], v_taddr [MAX_VEC];

    tb_clock_gen #(.PERIOD_NS(40.0), .RESET_CYCLES(5)) u_clk (.clk_o(clk), .reset_o(reset_i));

    axil_xbar u_dut (
        .clk(clk), .reset_i(reset_i), .pause_req_i(pause_req), .pause_ack_o(pause_ack),
        .slv_req_i(slv_req), .slv_resp_o(slv_resp), .mst_req_o(mst_req),
        .mst_resp_i(mst_resp), .addr_map_i(addr_map)
    );

    for (genvar j = 0; j < NUM_MST; j++) begin : g_mem
        tb_target_mem u_mem (.clk(clk), .reset_i(reset_i), .req_i(mst_req[j]),
                             .resp_o(mst_resp[j]));
    end

    tb_axil_checker u_chk (
        .clk(clk), .reset_i(reset_i), .slv_req_i(slv_req), .slv_resp_i(slv_resp),
        .mst_req_i(mst_req), .mst_resp_i(mst_resp), .pause_ack_i(pause_ack),
        .start_i(start), .check_i(check), .test_id_i(test_id), .port_i(chk_port),
        .exp_resp_i(exp_resp), .exp_rdata_i(exp_rdata), .chk_data_i(chk_data),
        .chk_tgt_i(chk_tgt), .exp_tgt_i(exp_tgt), .exp_taddr_i(exp_taddr),
        .pass_cnt_o(pass_cnt), .fail_cnt_o(fail_cnt)
    );

    // Presents a request and leaves it held until accepted
    task automatic issue(input int p, input bit wr, input logic [31:0] addr,
                         input logic [31:0] data, input logic [3:0] strb);
        slv_req[p].aw_valid <= wr;
        slv_req[p].w_valid  <= wr;
        slv_req[p].aw_addr  <= addr;
        slv_req[p].w_data   <= data;
        slv_req[p].w_strb   <= strb;
        slv_req[p].ar_valid <= !wr;
        slv_req[p].ar_addr  <= addr;
    endtask

    task automatic finish(input int p);
        bit accepted, done;
        accepted = 1'b0;
        done     = 1'b0;
        while (!done) begin
            @(posedge clk);
            if (!accepted && ((slv_req[p].aw_valid && slv_resp[p].aw_ready) ||
                              (slv_req[p].ar_valid && slv_resp[p].ar_ready))) begin
                accepted = 1'b1;
                slv_req[p].aw_valid <= 1'b0;
                slv_req[p].w_valid  <= 1'b0;
                slv_req[p].ar_valid <= 1'b0;
            end
            done = slv_resp[p].b_valid || slv_resp[p].r_valid;
        end
    endtask

    task automatic request_check(input int k, input int p, input bit use_tgt);
        @(posedge clk);
        check     <= 1'b1;
        chk_port  <= p;
        exp_resp  <= v_resp[k][1:0];
        exp_rdata <= v_rdata[k];
        chk_data  <= (v_op[k] != "W" && v_op[k] != "C");
        chk_tgt   <= use_tgt;
        exp_tgt   <= int'(v_tgt[k]);
        exp_taddr <= v_taddr[k];
        @(posedge clk);
        check <= 1'b0;
    endtask

    task automatic run_vector(input int k);
        int p;
        p = int'(v_port[k]);
        @(posedge clk);
        start   <= 1'b1;
        test_id <= k;
        @(posedge clk);
        start <= 1'b0;
        if (v_op[k] == "C") begin
            issue(0, 1'b1, v_addr[k], v_wdata[k], v_strb[k][3:0]);
            issue(1, 1'b1, v_addr[k] + 32'd4, v_rdata[k], v_strb[k][3:0]);
            fork
                finish(0);
                finish(1);
            join
            request_check(k, 0, 1'b0);
            request_check(k, 1, 1'b0);
        end else if (v_op[k] == "P") begin
            pause_req <= 1'b1;
            do @(posedge clk); while (!pause_ack);
            issue(p, 1'b0, v_addr[k], '0, '0);
            repeat (4) @(posedge clk);
            pause_req <= 1'b0;
            // The held request is taken in the cycle the ack falls
            fork
                begin
                    do @(posedge clk); while (pause_ack);
                end
                finish(p);
            join
            request_check(k, p, 1'b1);
        end else begin
            issue(p, v_op[k] == "W", v_addr[k], v_wdata[k], v_strb[k][3:0]);
            finish(p);
            request_check(k, p, 1'b1);
        end
    endtask

    // Cycle limit against a stuck handshake
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            $display("Timeout: the run did not finish within %0d cycles", limit);
            $display("*** FAILED ***");
            $finish;
        end
    end

    initial begin
        int fd, n;
        string line;
        void'($urandom(32'h3ce8));
        slv_req   = '0;
        slv_req[0].b_ready = 1'b1;
        slv_req[0].r_ready = 1'b1;
        slv_req[1].b_ready = 1'b1;
        slv_req[1].r_ready = 1'b1;
        pause_req = 1'b0;
        {start, check, chk_data, chk_tgt, exp_resp, exp_rdata, exp_taddr} = '0;
        {test_id, chk_port, exp_tgt, cycles, nvec} = '0;
        limit = 1000000;
        addr_map[0] = '{idx: 1'b0, start_addr: 32'h1000, end_addr: 32'h1100};
        addr_map[1] = '{idx: 1'b1, start_addr: 32'h2000, end_addr: 32'h2100};
        fd = $fopen("axil_xbar_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test data file");
            $display("*** FAILED ***");
            $finish;
        end else begin
            while (!$feof(fd) && nvec < MAX_VEC) begin
                n = $fgets(line, fd);
                if (n > 1 && line.substr(0, 0) != "#") begin
                    n = $sscanf(line, "%s %h %h %h %h %h %h %h %h", v_op[nvec], v_port[nvec],
                                v_addr[nvec], v_wdata[nvec], v_strb[nvec], v_rdata[nvec],
                                v_resp[nvec], v_tgt[nvec], v_taddr[nvec]);
                    if (n == 9) nvec++;
                end
            end
            $fclose(fd);
            limit = nvec * 60 + 200;
            do @(posedge clk); while (reset_i);
            for (int k = 0; k < nvec; k++) run_vector(k);
            repeat (2) @(posedge clk);
            $display("Checks done: %0d passed, %0d failed", pass_cnt, fail_cnt);
            if (fail_cnt == 0 && pass_cnt > 0) begin
                $display("*** PASSED ***");
            end else begin
                $display("*** FAILED ***");
            end
            $finish;
        end
    end

endmodule

// Target memory of 64 words with a random response wait
module tb_target_mem import axil_xbar_pkg::*; (
    input  logic       clk,
    input  logic       reset_i,
    input  axil_req_t  req_i,
    output axil_resp_t resp_o
);

    logic [31:0] mem [64];
    logic [1:0]  st_q, wait_q;
    logic [31:0] rdata_q;

    initial begin
        for (int k = 0; k < 64; k++) mem[k] = 32'hA5000000 ^ (k * 32'h01010101);
    end

    always_comb begin
        resp_o          = '0;
        resp_o.aw_ready = (st_q == 2'd0) && req_i.aw_valid && req_i.w_valid;
        resp_o.w_ready  = resp_o.aw_ready;
        resp_o.ar_ready = (st_q == 2'd0) && req_i.ar_valid && !req_i.aw_valid;
        resp_o.b_valid  = (st_q == 2'd1) && (wait_q == 2'd0);
        resp_o.r_valid  = (st_q == 2'd2) && (wait_q == 2'd0);
        resp_o.r_data   = resp_o.r_valid ? rdata_q : '0;
        resp_o.b_resp   = RESP_OKAY;
        resp_o.r_resp   = RESP_OKAY;
    end

    always @(posedge clk) begin
        if (reset_i) begin
            st_q   <= 2'd0;
            wait_q <= 2'd0;
        end else if (st_q == 2'd0) begin
            wait_q <= 2'($urandom % 4);
            if (resp_o.aw_ready) begin
                for (int b = 0; b < 4; b++) begin
                    if (req_i.w_strb[b]) begin
                        mem[req_i.aw_addr[7:2]][8*b +: 8] <= req_i.w_data[8*b +: 8];
                    end
                end
                st_q <= 2'd1;
            end else if (resp_o.ar_ready) begin
                rdata_q <= mem[req_i.ar_addr[7:2]];
                st_q    <= 2'd2;
            end
        end else if (wait_q != 2'd0) begin
            wait_q <= wait_q - 2'd1;
        end else if ((resp_o.b_valid && req_i.b_ready) || (resp_o.r_valid && req_i.r_ready)) begin
            st_q <= 2'd0;
        end
    end

endmodule

// ==== tb_clock_gen.sv ====
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter real PERIOD_NS    = 40.0,
    parameter int  RESET_CYCLES = 5
) (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
    end

    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        reset_o <= 1'b0;
    end

endmodule
